// ==== hdl/io_ctrl_pkg.sv ====
//##########################################################
// I/O controller shared definitions.
// Register map, widths and reset values for three pad ports.
//##########################################################

`default_nettype none

package io_ctrl_pkg;

	//##########################################################
	// Sizes
	//##########################################################

	localparam int NUM_PORTS = 3; // Pad ports A, B, C.
	localparam int PIN_W     = 7; // Pins per port.
	localparam int REG_W     = 8; // Host register width.
	localparam int ADDR_W    = 4; // Host register address.

	typedef logic [1:0]       port_idx_t;
	typedef logic [REG_W-1:0] reg_t;
	typedef logic [PIN_W-1:0] pins_t;

	//##########################################################
	// Register map
	//##########################################################

	localparam logic [ADDR_W-1:0] ADDR_VERSION   = 4'd0; // Board straps.
	localparam logic [ADDR_W-1:0] ADDR_DATA_BASE = 4'd1; // Data A, B, C.
	localparam logic [ADDR_W-1:0] ADDR_CTRL_BASE = 4'd4; // Control A, B, C.

	// Addresses 7 to 15 held the serial registers and now read as zero.

	//##########################################################
	// Bit positions and reset values
	//##########################################################

	localparam int CTRL_IRQ_BIT = 7; // Pin-6 interrupt enable.
	localparam int IRQ_PIN      = 6; // Interrupt source, active low.

	localparam reg_t REG_RST = '0; // All host registers.

endpackage

`default_nettype wire

// ==== hdl/io_reg_bus_if.sv ====
//##########################################################
// Decoded register write bus.
// Carries one port-indexed write from the decoder to the ports.
//##########################################################

`timescale 1ns/1ps
`default_nettype none

interface io_reg_bus_if;

	logic                   wr;      // One cycle per accepted write.
	io_ctrl_pkg::port_idx_t port;    // Target port.
	logic                   is_ctrl; // Control, else data register.
	io_ctrl_pkg::reg_t      wdata;

	// Driven by the host decoder.
	modport decoder
	(
		output wr,
		output port,
		output is_ctrl,
		output wdata
	);

	// Seen by every port block.
	modport port_blk
	(
		input wr,
		input port,
		input is_ctrl,
		input wdata
	);

endinterface

`default_nettype wire

// ==== hdl/io_host_decode.sv ====
//##########################################################
// Host write decoder.
// Maps host write cycles onto port-indexed register writes.
//##########################################################

`timescale 1ns/1ps
`default_nettype none

module io_host_decode
	(
	input  wire                                 MCLK,
	input  wire                                 rst_i,
	input  wire logic                           wr_i,
	input  wire logic [io_ctrl_pkg::ADDR_W-1:0] addr_i,
	input  wire io_ctrl_pkg::reg_t              wdata_i,
	io_reg_bus_if.decoder                       bus
	);

	logic [io_ctrl_pkg::ADDR_W-1:0] data_off;
	logic [io_ctrl_pkg::ADDR_W-1:0] ctrl_off;
	logic                           hit_data;
	logic                           hit_ctrl;

	//##########################################################
	// Address decode
	//##########################################################

	always_comb
	begin
		data_off = addr_i - io_ctrl_pkg::ADDR_DATA_BASE; // Wraps high below base.
		ctrl_off = addr_i - io_ctrl_pkg::ADDR_CTRL_BASE;
		hit_data = data_off < io_ctrl_pkg::NUM_PORTS;
		hit_ctrl = ctrl_off < io_ctrl_pkg::NUM_PORTS;
	end

	//##########################################################
	// Bus drive
	//##########################################################

	always_comb
	begin
		bus.wr      = wr_i & (hit_data | hit_ctrl) & ~rst_i; // Version and 7-15 drop.
		bus.is_ctrl = hit_ctrl;
		if (hit_ctrl)
		begin
			bus.port = io_ctrl_pkg::port_idx_t'(ctrl_off);
		end
		else
		begin
			bus.port = io_ctrl_pkg::port_idx_t'(data_off);
		end
		bus.wdata   = wdata_i; // Straight through.
	end

endmodule

`default_nettype wire

// ==== hdl/io_port_regs.sv ====
//##########################################################
// One pad port.
// Data and control registers, pin drive and pin-6 interrupt.
//##########################################################

`timescale 1ns/1ps
`default_nettype none

module io_port_regs
	#(
	parameter int PORT_ID = 0
	)
	(
	input  wire                        MCLK,
	input  wire                        rst_i,
	io_reg_bus_if.port_blk             bus,
	input  wire io_ctrl_pkg::pins_t    pins_i,
	output io_ctrl_pkg::reg_t          data_o,
	output io_ctrl_pkg::reg_t          ctrl_o,
	output io_ctrl_pkg::pins_t         dir_o,
	output io_ctrl_pkg::pins_t         out_o,
	output logic                       irq_o
	);

	localparam io_ctrl_pkg::port_idx_t MY_IDX = io_ctrl_pkg::port_idx_t'(PORT_ID);

	io_ctrl_pkg::reg_t data_q;
	io_ctrl_pkg::reg_t ctrl_q;
	logic              sel;

	assign sel = bus.wr & (bus.port == MY_IDX); // Strobe for this port.

	//##########################################################
	// Registers
	//##########################################################

	always_ff @(posedge MCLK)
	begin
		if (rst_i)
		begin
			data_q <= io_ctrl_pkg::REG_RST;
		end
		else if (sel & ~bus.is_ctrl)
		begin
			data_q <= bus.wdata;
		end
	end

	// Reset leaves every pin as input.
	always_ff @(posedge MCLK)
	begin
		if (rst_i)
		begin
			ctrl_q <= io_ctrl_pkg::REG_RST;
		end
		else if (sel & bus.is_ctrl)
		begin
			ctrl_q <= bus.wdata;
		end
	end

	//##########################################################
	// Pin side
	//##########################################################

	// Control bit set makes the pin an output.
	assign dir_o = ~ctrl_q[io_ctrl_pkg::PIN_W-1:0]; // 1 is input.
	assign out_o = data_q[io_ctrl_pkg::PIN_W-1:0];

	// Level interrupt from pin 6.
	assign irq_o = ~pins_i[io_ctrl_pkg::IRQ_PIN] & ctrl_q[io_ctrl_pkg::CTRL_IRQ_BIT];

	assign data_o = data_q;
	assign ctrl_o = ctrl_q; // For readback.

endmodule

`default_nettype wire

// ==== hdl/io_read_mux.sv ====
//##########################################################
// Host read path and interrupt line.
// Registered readback of straps, ports and control values.
//##########################################################

`timescale 1ns/1ps
`default_nettype none

module io_read_mux
	(
	input  wire                                 MCLK,
	input  wire                                 rst_i,
	input  wire logic [io_ctrl_pkg::ADDR_W-1:0] addr_i,
	input  wire logic                           overseas_i,
	input  wire logic                           pal_i,
	input  wire logic                           disk_i,
	input  wire logic                           tmss_i,
	input  wire io_ctrl_pkg::pins_t             pins_i [io_ctrl_pkg::NUM_PORTS],
	input  wire io_ctrl_pkg::reg_t              data_i [io_ctrl_pkg::NUM_PORTS],
	input  wire io_ctrl_pkg::reg_t              ctrl_i [io_ctrl_pkg::NUM_PORTS],
	input  wire logic [io_ctrl_pkg::NUM_PORTS-1:0] irq_i,
	output io_ctrl_pkg::reg_t                   rdata_o,
	output logic                                irq_n_o
	);

	io_ctrl_pkg::reg_t version;
	io_ctrl_pkg::reg_t rd_next;
	io_ctrl_pkg::reg_t rdata_q;

	// Straps in the top three bits, TMSS at the bottom.
	assign version = {overseas_i, pal_i, disk_i, 4'h0, tmss_i};

	//##########################################################
	// Read select
	//##########################################################

	always_comb
	begin
		rd_next = io_ctrl_pkg::REG_RST; // Unmapped reads as zero.
		if (addr_i == io_ctrl_pkg::ADDR_VERSION)
		begin
			rd_next = version;
		end
		for (int p = 0; p < io_ctrl_pkg::NUM_PORTS; p++)
		begin
			if (addr_i == io_ctrl_pkg::ADDR_DATA_BASE + io_ctrl_pkg::ADDR_W'(p))
			begin
				rd_next = {data_i[p][io_ctrl_pkg::REG_W-1], pins_i[p]}; // Live pins.
			end
			if (addr_i == io_ctrl_pkg::ADDR_CTRL_BASE + io_ctrl_pkg::ADDR_W'(p))
			begin
				rd_next = ctrl_i[p];
			end
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (rst_i)
		begin
			rdata_q <= io_ctrl_pkg::REG_RST;
		end
		else
		begin
			rdata_q <= rd_next;
		end
	end

	assign rdata_o = rdata_q;

	//##########################################################
	// Interrupt
	//##########################################################

	assign irq_n_o = ~|irq_i; // Any port pulls it low.

endmodule

`default_nettype wire

// ==== hdl/io_ctrl_top.sv ====
//##########################################################
// Pad port I/O controller top level.
// Host decoder, three port blocks and the read path.
//##########################################################

`timescale 1ns/1ps
`default_nettype none

module io_ctrl_top
	(
	input  wire                                 MCLK,
	input  wire                                 rst_i,
	input  wire logic                           wr_i,
	input  wire logic [io_ctrl_pkg::ADDR_W-1:0] addr_i,
	input  wire io_ctrl_pkg::reg_t              wdata_i,
	input  wire logic                           overseas_i,
	input  wire logic                           pal_i,
	input  wire logic                           disk_i,
	input  wire logic                           tmss_i,
	input  wire io_ctrl_pkg::pins_t             port_a_i,
	input  wire io_ctrl_pkg::pins_t             port_b_i,
	input  wire io_ctrl_pkg::pins_t             port_c_i,
	output io_ctrl_pkg::pins_t                  port_a_dir_o,
	output io_ctrl_pkg::pins_t                  port_b_dir_o,
	output io_ctrl_pkg::pins_t                  port_c_dir_o,
	output io_ctrl_pkg::pins_t                  port_a_o,
	output io_ctrl_pkg::pins_t                  port_b_o,
	output io_ctrl_pkg::pins_t                  port_c_o,
	output io_ctrl_pkg::reg_t                   rdata_o,
	output logic                                irq_n_o
	);

	io_ctrl_pkg::pins_t                port_pins [io_ctrl_pkg::NUM_PORTS];
	io_ctrl_pkg::pins_t                port_dir  [io_ctrl_pkg::NUM_PORTS];
	io_ctrl_pkg::pins_t                port_out  [io_ctrl_pkg::NUM_PORTS];
	io_ctrl_pkg::reg_t                 port_data [io_ctrl_pkg::NUM_PORTS];
	io_ctrl_pkg::reg_t                 port_ctrl [io_ctrl_pkg::NUM_PORTS];
	logic [io_ctrl_pkg::NUM_PORTS-1:0] port_irq;

	io_reg_bus_if reg_bus();

	// Index 0 is port A.
	assign port_pins[0] = port_a_i;
	assign port_pins[1] = port_b_i;
	assign port_pins[2] = port_c_i;

	assign port_a_dir_o = port_dir[0];
	assign port_b_dir_o = port_dir[1];
	assign port_c_dir_o = port_dir[2];

	assign port_a_o = port_out[0];
	assign port_b_o = port_out[1];
	assign port_c_o = port_out[2];

	//##########################################################
	// Write side
	//##########################################################

	io_host_decode u_decode
		(
		.MCLK(MCLK),
		.rst_i(rst_i),
		.wr_i(wr_i),
		.addr_i(addr_i),
		.wdata_i(wdata_i),
		.bus(reg_bus)
		);

	for (genvar g = 0; g < io_ctrl_pkg::NUM_PORTS; g++)
	begin : g_port
		io_port_regs #(.PORT_ID(g)) u_port
			(
			.MCLK(MCLK),
			.rst_i(rst_i),
			.bus(reg_bus),
			.pins_i(port_pins[g]),
			.data_o(port_data[g]),
			.ctrl_o(port_ctrl[g]),
			.dir_o(port_dir[g]),
			.out_o(port_out[g]),
			.irq_o(port_irq[g])
			);
	end

	//##########################################################
	// Read side
	//##########################################################

	io_read_mux u_read
		(
		.MCLK(MCLK),
		.rst_i(rst_i),
		.addr_i(addr_i),
		.overseas_i(overseas_i),
		.pal_i(pal_i),
		.disk_i(disk_i),
		.tmss_i(tmss_i),
		.pins_i(port_pins),
		.data_i(port_data),
		.ctrl_i(port_ctrl),
		.irq_i(port_irq),
		.rdata_o(rdata_o),
		.irq_n_o(irq_n_o)
		);

endmodule

`default_nettype wire

// ==== testbench/io_ctrl_assertions.sv ====
//##########################################################
// Bound checks on the I/O controller top level.
// Interrupt rule, direction changes and known read data.
//##########################################################

`timescale 1ns/1ps
`default_nettype none

module io_ctrl_assertions
	(
	input  wire                                 MCLK,
	input  wire                                 rst_i,
	input  wire logic                           wr_i,
	input  wire logic [io_ctrl_pkg::ADDR_W-1:0] addr_i,
	input  wire io_ctrl_pkg::pins_t             pins_i [io_ctrl_pkg::NUM_PORTS],
	input  wire io_ctrl_pkg::reg_t              ctrl_i [io_ctrl_pkg::NUM_PORTS],
	input  wire io_ctrl_pkg::pins_t             dir_i  [io_ctrl_pkg::NUM_PORTS],
	input  wire io_ctrl_pkg::reg_t              rdata_i,
	input  wire logic                           irq_n_i
	);

	logic irq_any;

	always_comb
	begin
		irq_any = 1'b0;
		for (int p = 0; p < io_ctrl_pkg::NUM_PORTS; p++)
			irq_any = irq_any | (ctrl_i[p][io_ctrl_pkg::CTRL_IRQ_BIT]
				& ~pins_i[p][io_ctrl_pkg::IRQ_PIN]); // Enabled and pin low.
	end

	a_irq_rule: assert property (@(posedge MCLK) disable iff (rst_i) irq_n_i == ~irq_any)
		else $error("irq_n_o does not follow the pin 6 interrupt rule");

	// Direction moves only on the edge of a control write to that port.
	for (genvar g = 0; g < io_ctrl_pkg::NUM_PORTS; g++)
	begin : g_dir
		a_dir_write: assert property (@(posedge MCLK) disable iff (rst_i)
			!$stable(dir_i[g]) |->
				$past(wr_i && addr_i == io_ctrl_pkg::ADDR_CTRL_BASE + io_ctrl_pkg::ADDR_W'(g)))
			else $error("port %0d direction changed without a control write", g);
	end

	a_rdata_known: assert property (@(posedge MCLK) disable iff (rst_i) !$isunknown(rdata_i))
		else $error("rdata_o is unknown after reset");

endmodule

bind io_ctrl_top io_ctrl_assertions u_assertions
	(
	.MCLK(MCLK),
	.rst_i(rst_i),
	.wr_i(wr_i),
	.addr_i(addr_i),
	.pins_i(port_pins),
	.ctrl_i(port_ctrl),
	.dir_i(port_dir),
	.rdata_i(rdata_o),
	.irq_n_i(irq_n_o)
	);

`default_nettype wire

// ==== testbench/io_ctrl_tb.sv ====
//##########################################################
// Testbench for the pad port I/O controller.
// Table-driven writes, readback, straps, pins and interrupt.
//##########################################################

`timescale 1ns/1ps
`default_nettype none

module io_ctrl_tb;

	localparam int CHK_NONE   = 0;
	localparam int CHK_RD     = 1; // Compare rdata_o.
	localparam int CHK_OUT    = 2;
	localparam int CHK_DIR    = 3;
	localparam int CHK_IRQ    = 4;
	localparam int RST_CYCLES = 16;
	localparam int WAIT_LIMIT = 40;

	logic               MCLK;
	logic               rst_i;
	logic               wr_i;
	logic [3:0]         addr_i;
	io_ctrl_pkg::reg_t  wdata_i;
	logic               overseas_i, pal_i, disk_i, tmss_i;
	io_ctrl_pkg::pins_t pin_a, pin_b, pin_c;
	io_ctrl_pkg::pins_t dir_a, dir_b, dir_c;
	io_ctrl_pkg::pins_t out_a, out_b, out_c;
	io_ctrl_pkg::reg_t  rdata_o;
	logic               irq_n_o;

	//##########################################################
	// Stimulus table and register model
	//##########################################################

	string       t_name  [$];
	logic        t_wr    [$];
	logic [3:0]  t_addr  [$];
	logic [7:0]  t_data  [$];
	logic [20:0] t_pins  [$]; // Ports C, B, A.
	logic [3:0]  t_strap [$]; // Overseas, PAL, disk, TMSS.
	int          t_chk   [$];
	int          t_port  [$];
	logic [7:0]  t_exp   [$];

	logic [7:0]  m_data [3];
	logic [7:0]  m_ctrl [3];
	logic [6:0]  cur_pins [3];
	logic [3:0]  cur_straps;
	logic [31:0] lcg_state;
	int          errors;
	int          steps;
	bit          settled;

	always #5 MCLK = ~MCLK;

	io_ctrl_top dut
		(
		.MCLK(MCLK),
		.rst_i(rst_i),
		.wr_i(wr_i),
		.addr_i(addr_i),
		.wdata_i(wdata_i),
		.overseas_i(overseas_i),
		.pal_i(pal_i),
		.disk_i(disk_i),
		.tmss_i(tmss_i),
		.port_a_i(pin_a),
		.port_b_i(pin_b),
		.port_c_i(pin_c),
		.port_a_dir_o(dir_a),
		.port_b_dir_o(dir_b),
		.port_c_dir_o(dir_c),
		.port_a_o(out_a),
		.port_b_o(out_b),
		.port_c_o(out_c),
		.rdata_o(rdata_o),
		.irq_n_o(irq_n_o)
		);

	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	function automatic void model_write(input logic [3:0] a, input logic [7:0] d);
		if (a >= 4'd1 && a <= 4'd3)
			m_data[a - 4'd1] = d;
		else if (a >= 4'd4 && a <= 4'd6)
			m_ctrl[a - 4'd4] = d;
	endfunction

	function automatic logic [7:0] exp_read(input logic [3:0] a);
		if (a == 4'd0)
			return {cur_straps[3:1], 4'h0, cur_straps[0]};
		else if (a <= 4'd3)
			return {m_data[a - 4'd1][7], cur_pins[a - 4'd1]}; // Data bit 7 over the pins.
		else if (a <= 4'd6)
			return m_ctrl[a - 4'd4];
		return 8'h00;
	endfunction

	function automatic logic [7:0] exp_irq();
		for (int p = 0; p < 3; p++)
		begin
			if (m_ctrl[p][7] && !cur_pins[p][6])
				return 8'h00;
		end
		return 8'h01;
	endfunction

	task automatic add_step(input string name, input logic wr, input logic [3:0] addr,
		input logic [7:0] data, input int chk, input int port);
		logic [7:0] exp;
		if (wr)
			model_write(addr, data);
		case (chk)
			CHK_RD:  exp = exp_read(addr);
			CHK_OUT: exp = {1'b0, m_data[port][6:0]};
			CHK_DIR: exp = {1'b0, ~m_ctrl[port][6:0]}; // 1 is input.
			CHK_IRQ: exp = exp_irq();
			default: exp = 8'h00;
		endcase
		t_name.push_back(name);
		t_wr.push_back(wr);
		t_addr.push_back(addr);
		t_data.push_back(data);
		t_pins.push_back({cur_pins[2], cur_pins[1], cur_pins[0]});
		t_strap.push_back(cur_straps);
		t_chk.push_back(chk);
		t_port.push_back(port);
		t_exp.push_back(exp);
	endtask

	task automatic build_table();
		logic [7:0] r;
		for (int p = 0; p < 3; p++)
		begin
			m_data[p]   = 8'h00;
			m_ctrl[p]   = 8'h00;
			cur_pins[p] = 7'h7F;
		end
		cur_straps = 4'h0;
		for (int p = 0; p < 3; p++)
		begin
			add_step($sformatf("reset_dir_%0d", p), 0, 4'd0, 8'h00, CHK_DIR, p);
			add_step($sformatf("reset_out_%0d", p), 0, 4'd0, 8'h00, CHK_OUT, p);
			add_step($sformatf("reset_ctrl_%0d", p), 0, 4'(4 + p), 8'h00, CHK_RD, 0);
		end
		add_step("reset_irq", 0, 4'd0, 8'h00, CHK_IRQ, 0);
		for (int p = 0; p < 3; p++)
		begin
			r = lcg_byte();
			add_step($sformatf("data_wr_%0d", p), 1, 4'(1 + p), r, CHK_OUT, p);
		end
		for (int p = 0; p < 3; p++)
		begin
			r = lcg_byte();
			cur_pins[p] = r[6:0];
			add_step($sformatf("data_rd_%0d", p), 0, 4'(1 + p), 8'h00, CHK_RD, 0);
		end
		for (int p = 0; p < 3; p++)
		begin
			r = lcg_byte();
			add_step($sformatf("ctrl_wr_%0d", p), 1, 4'(4 + p), r, CHK_DIR, p);
			add_step($sformatf("ctrl_rd_%0d", p), 0, 4'(4 + p), 8'h00, CHK_RD, 0);
			for (int q = 0; q < 3; q++)
			begin
				if (q != p)
					add_step($sformatf("ctrl_keep_%0d_%0d", p, q), 0, 4'd0, 8'h00, CHK_DIR, q);
			end
		end
		for (int k = 0; k < 6; k++)
		begin
			r = lcg_byte();
			cur_straps = r[3:0];
			add_step($sformatf("version_%0d", k), 0, 4'd0, 8'h00, CHK_RD, 0);
		end
		cur_straps = 4'h0;

		//##########################################################
		// Interrupt on port B, then unmapped addresses
		//##########################################################
		for (int p = 0; p < 3; p++)
			cur_pins[p] = 7'h7F;
		add_step("irq_clear_a", 1, 4'd4, 8'h00, CHK_IRQ, 0);
		add_step("irq_clear_c", 1, 4'd6, 8'h00, CHK_IRQ, 0);
		add_step("irq_arm_b", 1, 4'd5, 8'h80, CHK_IRQ, 0);
		cur_pins[1][6] = 1'b0;
		add_step("irq_b_low", 0, 4'd0, 8'h00, CHK_IRQ, 0);
		cur_pins[1][6] = 1'b1;
		add_step("irq_b_high", 0, 4'd0, 8'h00, CHK_IRQ, 0);
		add_step("irq_disarm_b", 1, 4'd5, 8'h00, CHK_IRQ, 0);
		cur_pins[0][6] = 1'b0;
		cur_pins[1][6] = 1'b0;
		add_step("irq_low_disarmed", 0, 4'd0, 8'h00, CHK_IRQ, 0);
		for (int p = 0; p < 3; p++)
			cur_pins[p] = 7'h7F;
		for (int a = 0; a < 16; a++)
		begin
			r = lcg_byte();
			if (a == 0 || a > 6)
				add_step($sformatf("unmapped_wr_%0d", a), 1, 4'(a), r, CHK_NONE, 0);
		end
		for (int p = 0; p < 3; p++)
		begin
			add_step($sformatf("unmapped_out_%0d", p), 0, 4'd0, 8'h00, CHK_OUT, p);
			add_step($sformatf("unmapped_data_%0d", p), 0, 4'(1 + p), 8'h00, CHK_RD, 0);
			add_step($sformatf("unmapped_ctrl_%0d", p), 0, 4'(4 + p), 8'h00, CHK_RD, 0);
		end
		cur_straps = 4'hF; // Nonzero version ahead of the zero reads.
		add_step("unmapped_version", 0, 4'd0, 8'h00, CHK_RD, 0);
		for (int a = 7; a < 16; a++)
			add_step($sformatf("unmapped_rd_%0d", a), 0, 4'(a), 8'h00, CHK_RD, 0);
	endtask

	//##########################################################
	// Apply and check
	//##########################################################

	function automatic logic [7:0] observe(input int chk, input int port);
		case (chk)
			CHK_RD:  return rdata_o;
			CHK_OUT: return {1'b0, (port == 0) ? out_a : ((port == 1) ? out_b : out_c)};
			CHK_DIR: return {1'b0, (port == 0) ? dir_a : ((port == 1) ? dir_b : dir_c)};
			CHK_IRQ: return {7'h00, irq_n_o};
			default: return 8'h00;
		endcase
	endfunction

	task automatic run_step(input int i);
		logic [7:0] act;
		@(negedge MCLK);
		wr_i    = t_wr[i];
		addr_i  = t_addr[i];
		wdata_i = t_data[i];
		{pin_c, pin_b, pin_a} = t_pins[i];
		{overseas_i, pal_i, disk_i, tmss_i} = t_strap[i];
		@(negedge MCLK); // Write and read register both take this edge.
		wr_i = 1'b0;
		act  = observe(t_chk[i], t_port[i]);
		steps++;
		if (t_chk[i] == CHK_NONE)
			$display("[INFO] %s: applied", t_name[i]);
		else if (act !== t_exp[i])
		begin
			errors++;
			$display("[ERROR] %s: expected %02h, actual %02h", t_name[i], t_exp[i], act);
		end
		else
			$display("[OK] %s: %02h", t_name[i], act);
	endtask

	task automatic wait_settled();
		int n;
		n       = 0;
		settled = 1'b0;
		while (!settled && n < WAIT_LIMIT)
		begin
			@(negedge MCLK);
			settled = ({dir_a, dir_b, dir_c} === {21{1'b1}}) && (irq_n_o === 1'b1)
				&& (rdata_o === 8'h00);
			n++;
		end
		if (!settled)
			$display("Timeout: DUT outputs did not reach reset state in %0d cycles", WAIT_LIMIT);
	endtask

	initial
	begin
		MCLK       = 1'b0;
		rst_i      = 1'b1;
		wr_i       = 1'b0;
		addr_i     = 4'd0;
		wdata_i    = 8'h00;
		overseas_i = 1'b0;
		pal_i      = 1'b0;
		disk_i     = 1'b0;
		tmss_i     = 1'b0;
		pin_a      = 7'h7F; // Pads idle high.
		pin_b      = 7'h7F;
		pin_c      = 7'h7F;
		errors     = 0;
		steps      = 0;
		lcg_state  = 32'd90;
		build_table();
		repeat (RST_CYCLES) @(posedge MCLK);
		@(negedge MCLK);
		rst_i = 1'b0;
		wait_settled();
		if (settled)
		begin
			foreach (t_name[i])
				run_step(i);
		end
		$display("Steps run: %0d of %0d, errors: %0d", steps, t_name.size(), errors);
		if (settled && errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== io_ctrl.f ====
hdl/io_ctrl_pkg.sv
hdl/io_reg_bus_if.sv
hdl/io_host_decode.sv
hdl/io_port_regs.sv
hdl/io_read_mux.sv
hdl/io_ctrl_top.sv
testbench/io_ctrl_assertions.sv
testbench/io_ctrl_tb.sv
